/* hw/ramAccessDecode.sv */
// RAM access decoder.
// Splits the byte address into bank, word address and byte offset, builds
// the lane write enables for the selected bank and lines the write data up
// with the lanes. Purely combinational.

`timescale 1ns/1ps

`include "ramSystem_defs.svh"

module ramAccessDecode import ramPkg::*; (
  input  logic    wr,         // Write this cycle.
  input  logic    be,         // Byte access when high, word access when low.
  input  byteAdrT adr,        // Byte address.
  input  wordT    wdata,      // Write data; bits 7:0 only for a byte write.
  ramPortIf.ctrl  bigPort,    // Bank 0, 32K words.
  ramPortIf.ctrl  smallPort   // Bank 1, 16K words.
);

  ////////////////////////////////////////////////////////////////////////
  // Address fields
  ////////////////////////////////////////////////////////////////////////

  localparam int BankBit = `RAM_ADR_W - 1;  // Selects bank 1 when set.
  localparam int HighBit = `RAM_ADR_W - 2;  // Top word address bit of bank 0.
  localparam int OffW = $clog2(`LANES);     // Byte offset bits below the word.

  logic    bankSel;     // Bank 1 is addressed.
  logic    outOfRange;  // Bank 1 with an address past its last word.
  wordAdrT wordAdr;
  byteOffT byteOff;

  assign bankSel = adr[BankBit];
  assign wordAdr = adr[BankBit-1:OffW];  // Same word index goes to both banks.
  assign byteOff = adr[OffW-1:0];

  // The small bank only has half the words, so its upper half is a hole.
  assign outOfRange = bankSel & adr[HighBit];

  ////////////////////////////////////////////////////////////////////////
  // Lane write enables
  ////////////////////////////////////////////////////////////////////////

  laneEnT laneSel;    // Lanes touched by the access, ignoring wr.
  laneEnT wrLanes;    // Lanes written this cycle in whichever bank is chosen.

  // A word access covers every lane. A byte access covers the one lane
  // named by the offset.
  always_comb begin
    if (be) begin
      laneSel = '0;
      laneSel[byteOff] = 1'b1;
    end else begin
      laneSel = '1;
    end
  end

  // Nothing is written on a read cycle or into the hole above bank 1.
  assign wrLanes = (wr && !outOfRange) ? laneSel : '0;

  // Only the addressed bank sees the strobes; the other one just reads.
  assign bigPort.laneEn   = bankSel ? '0 : wrLanes;
  assign smallPort.laneEn = bankSel ? wrLanes : '0;

  assign bigPort.wordAdr   = wordAdr;
  assign smallPort.wordAdr = wordAdr;  // The bank drops bit 14 itself.

  ////////////////////////////////////////////////////////////////////////
  // Write data
  ////////////////////////////////////////////////////////////////////////

  wordT laneData;

  // A byte write carries its value in bits 7:0. Copying it into every lane
  // means each lane can take its own slice and only the enable decides.
  assign laneData = be ? {`LANES{wdata[`LANE_W-1:0]}} : wdata;

  assign bigPort.wdata   = laneData;
  assign smallPort.wdata = laneData;

endmodule

/* hw/ramBank.sv */
// RAM bank.
// DEPTH words of four independent byte lanes. Each lane writes its byte on
// its own enable and returns the contents from before the write, so a read
// of the word being written sees the old value one clock later.

`timescale 1ns/1ps

`include "ramSystem_defs.svh"

module ramBank import ramPkg::*; #(
  parameter int DEPTH = `BIG_WORDS  // Words in this bank. Must be a power of two.
) (
  input  logic   clk,
  ramPortIf.mem  port               // Access from the decoder and data back out.
);

  ////////////////////////////////////////////////////////////////////////
  // Address
  ////////////////////////////////////////////////////////////////////////

  localparam int AdrW = $clog2(DEPTH);  // Address bits this bank decodes.

  logic [AdrW-1:0] cellAdr;

  // The shared word address is sized for the deepest bank. A shallower bank
  // keeps only its low bits; the decoder has already kept writes out of any
  // range this drops.
  assign cellAdr = port.wordAdr[AdrW-1:0];

  ////////////////////////////////////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////////////////////////////////////

  genvar lane;

  generate
    for (lane = 0; lane < `LANES; lane++) begin : gLane

      logic [`LANE_W-1:0] cells [DEPTH];  // One byte per word for this lane.
      logic [`LANE_W-1:0] rdByte;         // Registered read of this lane.

      // The read picks up the value stored before this edge, and the write
      // lands at the same edge. That makes the bank read-first.
      always_ff @(posedge clk) begin
        if (port.laneEn[lane]) begin
          cells[cellAdr] <= port.wdata[lane*`LANE_W +: `LANE_W];
        end
        rdByte <= cells[cellAdr];  // Reads on every edge whether or not it writes.
      end

      // Lanes sit side by side in the returned word with lane 0 lowest.
      assign port.rdata[lane*`LANE_W +: `LANE_W] = rdByte;

    end
  endgenerate

endmodule

/* hw/ramPkg.sv */
// RAM system types.
// Vector types for addresses, data words and lane enables, sized from the
// shared sizing macros so every block agrees on the widths.

package ramPkg;

`include "ramSystem_defs.svh"

  // Full byte address as seen at the top level.
  typedef logic [`RAM_ADR_W-1:0] byteAdrT;

  // One data word, all lanes side by side.
  typedef logic [`LANES*`LANE_W-1:0] wordT;

  // One write enable per byte lane.
  typedef logic [`LANES-1:0] laneEnT;

  // Word address within a bank. Sized for the deep bank; the small bank
  // ignores the top bit.
  typedef logic [$clog2(`BIG_WORDS)-1:0] wordAdrT;

  // Byte position within a word.
  typedef logic [$clog2(`LANES)-1:0] byteOffT;

endpackage

/* hw/ramPortIf.sv */
// RAM bank port.
// Carries one bank's lane write enables, word address and write data from
// the decoder to the bank, and the bank's read word on to the read selector.

`timescale 1ns/1ps

interface ramPortIf import ramPkg::*; ();

  laneEnT  laneEn;   // Per-lane write strobes, all zero on a read-only cycle.
  wordAdrT wordAdr;  // Word index; the bank takes the low bits it needs.
  wordT    wdata;    // Write word, byte data already copied to every lane.
  wordT    rdata;    // Old contents at wordAdr, one clock after the address.

  // The decoder side drives the access.
  modport ctrl (
    output laneEn,
    output wordAdr,
    output wdata
  );

  // The bank side stores and returns data.
  modport mem (
    input  laneEn,
    input  wordAdr,
    input  wdata,
    output rdata
  );

  // The read selector only looks at the returned word.
  modport sel (
    input rdata
  );

endinterface

/* hw/ramReadSelect.sv */
// RAM read selector.
// Keeps the attributes of the access issued at each edge so they line up
// with the bank data that comes back one clock later, then picks the bank,
// blanks the hole above bank 1 and aligns a byte read down to bits 7:0.

`timescale 1ns/1ps

`include "ramSystem_defs.svh"

module ramReadSelect import ramPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    be,          // Byte access flag of the current address.
  input  byteAdrT adr,         // Current byte address.
  ramPortIf.sel   bigPort,     // Read word from bank 0.
  ramPortIf.sel   smallPort,   // Read word from bank 1.
  output wordT    rdata        // Read result, one clock after adr.
);

  localparam int BankBit = `RAM_ADR_W - 1;
  localparam int HighBit = `RAM_ADR_W - 2;
  localparam int OffW = $clog2(`LANES);

  ////////////////////////////////////////////////////////////////////////
  // Access attributes, one clock behind the address
  ////////////////////////////////////////////////////////////////////////

  logic    bankQ;   // Bank 1 was addressed.
  logic    highQ;   // Top word address bit, which is a hole in bank 1.
  logic    beQ;     // The access was a byte access.
  byteOffT offQ;    // Byte offset of the access.

  // Captured at the same edge at which the banks read. After reset the
  // attributes describe an address in the hole, so the output stays zero
  // until a real read comes back.
  always_ff @(posedge clk) begin
    if (reset) begin
      bankQ <= 1'b1;
      highQ <= 1'b1;
      beQ   <= 1'b0;
      offQ  <= '0;
    end else begin
      bankQ <= adr[BankBit];
      highQ <= adr[HighBit];
      beQ   <= be;
      offQ  <= adr[OffW-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Select and align
  ////////////////////////////////////////////////////////////////////////

  logic outOfRangeQ;  // The returned data belongs to an address in the hole.
  wordT bankWord;     // Word from the bank that was addressed.
  wordT shifted;      // Addressed byte moved down to lane 0.

  // The range is judged again from the registered bits rather than taken
  // from the decoder, whose own test only stops writes.
  assign outOfRangeQ = bankQ & highQ;

  assign bankWord = bankQ ? smallPort.rdata : bigPort.rdata;

  assign shifted = bankWord >> (offQ * `LANE_W);  // Lane offQ ends up in 7:0.

  always_comb begin
    if (outOfRangeQ) begin
      rdata = '0;  // The hole reads as zero whatever the bank returned.
    end else if (beQ) begin
      rdata = '0;
      rdata[`LANE_W-1:0] = shifted[`LANE_W-1:0];  // Zero-extended byte.
    end else begin
      rdata = bankWord;  // Word reads ignore the offset.
    end
  end

endmodule

/* hw/ramSystem.sv */
// Banked on-chip RAM, 196,608 bytes.
// A 32K-word bank and a 16K-word bank side by side behind one byte address.
// Byte or word writes land at the clock edge; every cycle is also a read
// whose data appears one clock later. The hole above bank 1 reads as zero
// and ignores writes.

`timescale 1ns/1ps

`include "ramSystem_defs.svh"

module ramSystem import ramPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    wr,      // Write at this edge.
  input  logic    be,      // Byte access when high.
  input  byteAdrT adr,     // Byte address; bit 17 picks the bank.
  input  wordT    wdata,   // Write data, bits 7:0 for a byte write.
  output wordT    rdata    // Read data for the address of the previous edge.
);

  ////////////////////////////////////////////////////////////////////////
  // Bank ports
  ////////////////////////////////////////////////////////////////////////

  ramPortIf bigIf ();    // Decoder to bank 0 and on to the read selector.
  ramPortIf smallIf ();  // Decoder to bank 1 and on to the read selector.

  ////////////////////////////////////////////////////////////////////////
  // Decode, store, select
  ////////////////////////////////////////////////////////////////////////

  ramAccessDecode decode (
    .wr        (wr),
    .be        (be),
    .adr       (adr),
    .wdata     (wdata),
    .bigPort   (bigIf.ctrl),
    .smallPort (smallIf.ctrl)
  );

  // Bank 0 covers byte addresses 0x00000 to 0x1ffff.
  ramBank #(
    .DEPTH (`BIG_WORDS)
  ) bigBank (
    .clk  (clk),
    .port (bigIf.mem)
  );

  // Bank 1 covers 0x20000 to 0x2ffff.
  ramBank #(
    .DEPTH (`SMALL_WORDS)
  ) smallBank (
    .clk  (clk),
    .port (smallIf.mem)
  );

  ramReadSelect readSelect (
    .clk       (clk),
    .reset     (reset),
    .be        (be),
    .adr       (adr),
    .bigPort   (bigIf.sel),
    .smallPort (smallIf.sel),
    .rdata     (rdata)
  );

endmodule

/* include/ramSystem_defs.svh */
// Banked RAM system sizing.
// Address width, bank depths and byte lane count shared by the RAM blocks
// and the types built from them.

`ifndef RAMSYSTEM_DEFS_SVH
`define RAMSYSTEM_DEFS_SVH

// Byte address width. 196,608 bytes need 18 bits.
`define RAM_ADR_W 18

// Bank 0 is the deep bank and sets the word address width.
`define BIG_WORDS 32768

// Bank 1 holds half as many words. Bit 16 of its byte addresses must be zero.
`define SMALL_WORDS 16384

// Byte lanes per 32-bit word.
`define LANES 4

// Width of one byte lane.
`define LANE_W 8

`endif

/* ramSystem.f */
+incdir+include
hw/ramPkg.sv
hw/ramPortIf.sv
hw/ramAccessDecode.sv
hw/ramBank.sv
hw/ramReadSelect.sv
hw/ramSystem.sv
tb/ramSystem_assert.sv
tb/ramSystemTb.sv

/* run.sh */
#!/bin/sh
# Builds the banked RAM testbench with Verilator and runs it.
# The run passes only if the testbench prints its pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f ramSystem.f \
  --top-module ramSystemTb \
  -o ramSystemSim

output=$(./obj_dir/ramSystemSim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
  echo "run.sh: simulation passed"
  exit 0
fi

echo "run.sh: simulation did not pass"
exit 1

/* tb/ramSystemTb.sv */
// Testbench for the banked RAM.
// Fills both banks, then runs directed and random byte and word accesses.
// A byte-array model predicts every read, checked one clock after its address.

`timescale 1ns/1ps

`include "ramSystem_defs.svh"

module ramSystemTb import ramPkg::*; ();

  localparam int ClkPeriod = 4;
  localparam int ResetCycles = 8;
  localparam int MemBytes = (`BIG_WORDS + `SMALL_WORDS) * `LANES;  // 196,608 bytes.
  localparam int FillCycles = MemBytes / `LANES;   // One word write per cycle.
  localparam int DirectedCycles = 400;  // Bound on the four directed tests.
  localparam int StreamCycles = 400;
  localparam int RandomOps = 2000;
  localparam int TotalCycles = ResetCycles + FillCycles + DirectedCycles +
                               StreamCycles + RandomOps;
  localparam int MarginNs = 2000;

  logic    clk;
  logic    reset;
  logic    wr;
  logic    be;
  byteAdrT adr;
  wordT    wdata;
  wordT    rdata;

  logic [`LANE_W-1:0] refMem [MemBytes];  // Expected contents by byte address.
  logic [32:0] expQ [$];   // Check flag and expected rdata for the access in flight.
  logic checkEn;           // Cleared while the fill overwrites unknown contents.
  int checkCount;
  int errCount;
  int markChecks;
  int markErrs;

  ramSystem UUT (
    .clk   (clk),
    .reset (reset),
    .wr    (wr),
    .be    (be),
    .adr   (adr),
    .wdata (wdata),
    .rdata (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Bank 1 with bit 16 set lies past the last word.
  function automatic logic addrValid(byteAdrT a);
    return !(a[17] && a[16]);
  endfunction

  // Applies one access to the model. Word writes ignore the offset.
  function automatic void storeBytes(logic w, logic b, byteAdrT a, wordT d);
    int base;
    int i;
    if (!w || !addrValid(a)) return;  // Reads and the hole change nothing.
    base = int'(a) & ~3;
    if (b) begin
      refMem[int'(a)] = d[7:0];  // Byte data always comes from bits 7:0.
    end else begin
      for (i = 0; i < `LANES; i++) refMem[base + i] = d[i*8 +: 8];
    end
  endfunction

  // Word, or zero-extended byte, that a read of a should return.
  function automatic wordT expectedData(logic b, byteAdrT a);
    wordT w;
    int base;
    int i;
    if (!addrValid(a)) return '0;
    base = int'(a) & ~3;
    if (b) return {24'h0, refMem[int'(a)]};
    for (i = 0; i < `LANES; i++) w[i*8 +: 8] = refMem[base + i];
    return w;
  endfunction

  // Fill value built from every word address bit.
  function automatic wordT fillWord(byteAdrT a);
    return {a[17:2], ~a[17:2]} ^ 32'h3c5a96e1;
  endfunction

  // Random address; a quarter are crowded into few words to force reuse.
  function automatic byteAdrT randomAdr();
    byteAdrT a;
    a = byteAdrT'($urandom());
    if ($urandom_range(3, 0) == 0) a[15:6] = '0;
    return a;
  endfunction

  // The model reads before it writes, as the banks do.
  always @(posedge clk) begin
    if (reset) begin
      expQ.push_back({1'b1, 32'h0});  // Selector attributes clear to the hole.
    end else begin
      expQ.push_back({checkEn, expectedData(be, adr)});
      storeBytes(wr, be, adr, wdata);
    end
  end

  // rdata only moves at rising edges, so the falling edge sees it settled.
  always @(negedge clk) begin
    logic [32:0] e;
    if (expQ.size() > 0) begin
      e = expQ.pop_front();
      if (e[32]) compareValue("rdata", e[31:0], rdata);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic compareValue(string name, wordT expected, wordT actual);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("ERR %s exp=%08h got=%08h", name, expected, actual);
    end
  endtask

  task automatic issue(logic w, logic b, byteAdrT a, wordT d);
    @(negedge clk);
    checkEn = 1'b1;
    wr = w;
    be = b;
    adr = a;
    wdata = d;
  endtask

  // One idle read lets the last access reach its compare.
  task automatic endTest(string name);
    issue(1'b0, 1'b0, '0, '0);
    @(posedge clk);
    $display("test %s: %0d checks, %0d errors", name,
             checkCount - markChecks, errCount - markErrs);
    markChecks = checkCount;
    markErrs = errCount;
  endtask

  task automatic fillMemory();
    int w;
    for (w = 0; w < FillCycles; w++) begin
      @(negedge clk);
      checkEn = 1'b0;  // Old contents are still unknown.
      wr = 1'b1;
      be = 1'b0;
      adr = byteAdrT'(w * `LANES);
      wdata = fillWord(adr);
    end
  endtask

  task automatic wordRoundTrip();
    byteAdrT list [10];
    int i;
    list = '{18'h00000, 18'h00004, 18'h0fffc, 18'h10000, 18'h1fff8,
             18'h1fffc, 18'h20000, 18'h20006, 18'h2fff8, 18'h2fffc};
    for (i = 0; i < 10; i++) begin
      issue(1'b1, 1'b0, list[i], wordT'($urandom()));
      issue(1'b0, 1'b0, list[i], '0);
      // Same cell offset in the other bank, kept out of the hole.
      issue(1'b0, 1'b0, (list[i] ^ 18'h20000) & 18'h2ffff, '0);
    end
  endtask

  task automatic byteLaneWrite();
    byteAdrT bases [3];
    int i;
    int off;
    bases = '{18'h00100, 18'h1fff0, 18'h2abc0};
    for (i = 0; i < 3; i++) begin
      for (off = 0; off < `LANES; off++) begin
        // Upper data bits are noise that must not land anywhere.
        issue(1'b1, 1'b1, bases[i] + byteAdrT'(off), wordT'($urandom()));
        issue(1'b0, 1'b0, bases[i], '0);
      end
    end
  endtask

  task automatic byteReads();
    byteAdrT bases [2];
    int i;
    int off;
    bases = '{18'h00200, 18'h2fff0};
    for (i = 0; i < 2; i++) begin
      issue(1'b1, 1'b0, bases[i], wordT'($urandom()));
      for (off = 0; off < `LANES; off++) issue(1'b0, 1'b1, bases[i] + byteAdrT'(off), '0);
    end
  endtask

  task automatic outOfRange();
    byteAdrT holes [4];
    int i;
    holes = '{18'h30000, 18'h3fffc, 18'h31238, 18'h3abc0};
    for (i = 0; i < 4; i++) begin
      issue(1'b1, 1'b0, holes[i], wordT'($urandom()));
      issue(1'b1, 1'b1, holes[i] + 18'h1, wordT'($urandom()));
      issue(1'b0, 1'b0, holes[i], '0);
      issue(1'b0, 1'b1, holes[i] + 18'h1, '0);
      issue(1'b0, 1'b0, holes[i] & 18'h2ffff, '0);  // Word bank 1 would alias to.
      issue(1'b0, 1'b0, holes[i] & 18'h1ffff, '0);  // Bank 0 at the same offset.
    end
  endtask

  task automatic streamReads();
    byteAdrT a;
    int n;
    for (n = 0; n < 256; n++) issue(1'b0, 1'($urandom()), randomAdr(), '0);
    // Write and read the same address in one cycle, then read it back.
    for (n = 0; n < 64; n++) begin
      a = randomAdr();
      issue(1'b1, 1'($urandom()), a, wordT'($urandom()));
      issue(1'b0, 1'b0, a, '0);
    end
  endtask

  task automatic randomMix();
    int n;
    for (n = 0; n < RandomOps; n++) begin
      issue(1'($urandom()), 1'($urandom()), randomAdr(), wordT'($urandom()));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h2a5d26ba));
    reset = 1'b1;
    wr = 1'b0;
    be = 1'b0;
    adr = '0;
    wdata = '0;
    checkEn = 1'b0;
    checkCount = 0;
    errCount = 0;
    markChecks = 0;
    markErrs = 0;
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    fillMemory();
    endTest("fillMemory");
    wordRoundTrip();
    endTest("wordRoundTrip");
    byteLaneWrite();
    endTest("byteLaneWrite");
    byteReads();
    endTest("byteReads");
    outOfRange();
    endTest("outOfRange");
    streamReads();
    endTest("streamReads");
    randomMix();
    endTest("randomMix");
    $display("Totals: %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Budget is every planned stimulus cycle plus a margin.
  initial begin
    #(TotalCycles * ClkPeriod + MarginNs);
    $display("Timeout: the run did not finish within %0d ns",
             TotalCycles * ClkPeriod + MarginNs);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* tb/ramSystem_assert.sv */
// Assertions for the banked RAM.
// Watches the lane enables leaving the decoder and the read selector's
// output. Bound into the top level, where both bank ports are visible.

`timescale 1ns/1ps

`include "ramSystem_defs.svh"

module ramSystemAssert import ramPkg::*; (
  input logic    clk,
  input logic    reset,
  input logic    wr,
  input logic    be,
  input byteAdrT adr,
  input laneEnT  bigLaneEn,    // Decoder strobes to bank 0.
  input laneEnT  smallLaneEn,  // Decoder strobes to bank 1.
  input wordT    rdata
);

  logic hole;  // Address falls above the end of bank 1.

  assign hole = adr[`RAM_ADR_W-1] & adr[`RAM_ADR_W-2];

  // Only the addressed bank may see write strobes.
  oneBank: assert property (@(posedge clk) disable iff (reset)
    !((|bigLaneEn) && (|smallLaneEn)))
    else $error("write strobes reach both banks");

  // A read-only cycle writes nothing.
  noWrite: assert property (@(posedge clk) disable iff (reset)
    !wr |-> ((bigLaneEn == '0) && (smallLaneEn == '0)))
    else $error("lane strobes active with wr low");

  // A byte write in range touches a single lane.
  byteLane: assert property (@(posedge clk) disable iff (reset)
    (wr && be && !hole) |-> ($countones(bigLaneEn | smallLaneEn) == 1))
    else $error("byte write does not enable exactly one lane");

  // The hole reads as zero one clock later.
  holeZero: assert property (@(posedge clk) disable iff (reset)
    hole |=> (rdata == '0))
    else $error("rdata not zero after an address in the hole");

endmodule

bind ramSystem ramSystemAssert checks (
  .clk         (clk),
  .reset       (reset),
  .wr          (wr),
  .be          (be),
  .adr         (adr),
  .bigLaneEn   (bigIf.laneEn),
  .smallLaneEn (smallIf.laneEn),
  .rdata       (rdata)
);
